/* hw/text_geom_pkg.sv */
package text_geom_pkg;

   // one screen coordinate from the scanner, 640x480 fits in 10 bits
   typedef logic [9:0] coord_t;

   // pixel being drawn this clock
   typedef struct packed {
      coord_t draw_x;
      coord_t draw_y;
   } pixel_pos_t;

   // glyph cell size in pixels
   localparam int GLYPH_W = 8;
   localparam int GLYPH_H = 16;

   // pixel offset inside one glyph cell
   typedef logic [2:0] glyph_col_t;
   typedef logic [3:0] glyph_row_t;

   // fixed layout of the battle screen text
   // species name, top left
   localparam coord_t NAME_X0 = 10'd64;
   localparam coord_t NAME_Y0 = 10'd48;
   // hp label sits under the name
   localparam coord_t HPL_X0 = 10'd64;
   localparam coord_t HPL_Y0 = 10'd72;
   // readout follows the label with a two glyph gap
   localparam coord_t HPN_X0 = 10'd96;
   localparam coord_t HPN_Y0 = 10'd72;
   // move name in the bottom message box
   localparam coord_t MOVE_X0 = 10'd64;
   localparam coord_t MOVE_Y0 = 10'd400;

   // result of one field for the current pixel
   typedef struct packed {
      logic       hit;
      logic [7:0] chr;
      glyph_col_t col;
      glyph_row_t row;
   } field_hit_t;

   // request to the glyph rom stage
   typedef struct packed {
      logic [7:0] chr;
      glyph_col_t col;
      glyph_row_t row;
   } glyph_req_t;

endpackage

/* hw/battle_text_pkg.sv */
package battle_text_pkg;

   // plain ascii code
   typedef logic [7:0] char_t;

   // codes the formatter and the fields need
   localparam char_t CHR_BLANK = 8'h20;
   localparam char_t CHR_ZERO  = 8'h30;
   localparam char_t CHR_ONE   = 8'h31;
   localparam char_t CHR_SLASH = 8'h2f;

   // characters per text field
   localparam int NAME_LEN = 9;
   localparam int MOVE_LEN = 12;
   localparam int HPL_LEN  = 2;
   localparam int HPN_LEN  = 7;

   // strings, first character in the highest slot
   // so a string literal maps straight onto them
   typedef char_t [NAME_LEN-1:0] name_str_t;
   typedef char_t [MOVE_LEN-1:0] move_str_t;
   typedef char_t [HPL_LEN-1:0]  hpl_str_t;
   typedef char_t [HPN_LEN-1:0]  hpn_str_t;

   // constant label next to the readout
   localparam hpl_str_t HP_LABEL = "HP";

   // eight species, 26 moves in a 5-bit id
   typedef logic [2:0] species_id_t;
   typedef logic [4:0] move_id_t;
   localparam int MOVE_COUNT = 26;

   // hp up to 127
   typedef logic [6:0] hp_t;

endpackage

/* hw/battle_name_rom.sv */
`timescale 1ns/1ps

module battle_name_rom
   import battle_text_pkg::*;
(
   input  species_id_t species_id,
   input  move_id_t    move_id,
   output name_str_t   name_str,
   output move_str_t   move_str
);

   // species names, blank padded to 9
   always_comb begin
      case (species_id)
         3'd0:    name_str = "BLASTOISE";
         3'd1:    name_str = "CHARIZARD";
         3'd2:    name_str = "DRAGONITE";
         3'd3:    name_str = "GENGAR   ";
         3'd4:    name_str = "MEW      ";
         3'd5:    name_str = "PIKACHU  ";
         3'd6:    name_str = "VENUSAUR ";
         3'd7:    name_str = "WEEZING  ";
         default: name_str = {NAME_LEN{CHR_BLANK}};
      endcase
   end

   // move names, blank padded to 12
   // ids past the table show an empty box
   always_comb begin
      case (move_id)
         5'd0:    move_str = "HYDRO PUMP  ";
         5'd1:    move_str = "ICE BEAM    ";
         5'd2:    move_str = "CRUNCH      ";
         5'd3:    move_str = "AURA SPHERE ";
         5'd4:    move_str = "FLAMETHROWER";
         5'd5:    move_str = "THUNDERPUNCH";
         5'd6:    move_str = "AIR SLASH   ";
         5'd7:    move_str = "DRAGON CLAW ";
         5'd8:    move_str = "ENERGY BALL ";
         5'd9:    move_str = "SLUDGE BOMB ";
         5'd10:   move_str = "EARTHQUAKE  ";
         5'd11:   move_str = "PETAL DANCE ";
         5'd12:   move_str = "THUNDERBOLT ";
         5'd13:   move_str = "SLAM        ";
         5'd14:   move_str = "SURF        ";
         5'd15:   move_str = "THUNDER     ";
         5'd16:   move_str = "DARK PULSE  ";
         5'd17:   move_str = "SHADOW BALL ";
         5'd18:   move_str = "PSYCHIC     ";
         5'd19:   move_str = "PLAY ROUGH  ";
         5'd20:   move_str = "FLASH CANNON";
         5'd21:   move_str = "BUG BUZZ    ";
         5'd22:   move_str = "FIRE BLAST  ";
         5'd23:   move_str = "ROCK SLIDE  ";
         5'd24:   move_str = "DRAGON PULSE";
         5'd25:   move_str = "BLIZZARD    ";
         default: move_str = {MOVE_LEN{CHR_BLANK}};
      endcase
   end

endmodule

/* hw/hp_readout_fmt.sv */
`timescale 1ns/1ps

module hp_readout_fmt
   import battle_text_pkg::*;
(
   input  hp_t      cur_hp,
   input  hp_t      max_hp,
   output hpn_str_t hpn_str
);

   // three right aligned digits of one hp value
   function automatic logic [3*8-1:0] fmt_value(input hp_t value);
      char_t hundreds;
      char_t tens;
      char_t ones;
      int    below_100;
      int    tens_digit;
      below_100  = int'(value) % 100;
      tens_digit = below_100 / 10;
      // hp never reaches 200, so the hundreds place is 1 or empty
      hundreds = (value >= 7'd100) ? CHR_ONE : CHR_BLANK;
      // suppress the leading zero of two digit values
      if (hundreds == CHR_BLANK && tens_digit == 0) begin
         tens = CHR_BLANK;
      end else begin
         tens = CHR_ZERO + char_t'(tens_digit);
      end
      // ones always shown, so zero hp reads "  0"
      ones = CHR_ZERO + char_t'(int'(value) % 10);
      return {hundreds, tens, ones};
   endfunction

   logic [3*8-1:0] cur_chars;
   logic [3*8-1:0] max_chars;

   assign cur_chars = fmt_value(cur_hp);
   assign max_chars = fmt_value(max_hp);

   // current on the left, then slash, then maximum
   assign hpn_str = {cur_chars, CHR_SLASH, max_chars};

endmodule

/* hw/text_field.sv */
`timescale 1ns/1ps

module text_field
   import text_geom_pkg::*;
   import battle_text_pkg::*;
#(
   parameter type    str_t = name_str_t,
   parameter coord_t x0    = '0,
   parameter coord_t y0    = '0
)(
   input  pixel_pos_t pos,
   input  str_t       str,
   output field_hit_t hit
);

   // field width follows the string type
   localparam int     CHAR_COUNT = $bits(str_t) / $bits(char_t);
   localparam coord_t X_END      = coord_t'(int'(x0) + CHAR_COUNT * GLYPH_W);
   localparam coord_t Y_END      = coord_t'(int'(y0) + GLYPH_H);

   char_t [CHAR_COUNT-1:0] chars;
   coord_t                 x_off;
   coord_t                 y_off;
   logic                   in_field;
   int                     slot;

   assign chars = str;

   // offsets from the field origin
   assign x_off = pos.draw_x - x0;
   assign y_off = pos.draw_y - y0;

   // one glyph row high, count glyphs wide
   assign in_field = (pos.draw_x >= x0) && (pos.draw_x < X_END) &&
                     (pos.draw_y >= y0) && (pos.draw_y < Y_END);

   // leftmost glyph is the top slot
   assign slot = CHAR_COUNT - 1 - int'(x_off / GLYPH_W);

   always_comb begin
      hit = '{hit: 1'b0, chr: CHR_BLANK, col: '0, row: '0};
      if (in_field) begin
         hit.hit = 1'b1;
         hit.chr = chars[slot];
         hit.col = glyph_col_t'(x_off % GLYPH_W);
         hit.row = glyph_row_t'(y_off % GLYPH_H);
      end
   end

endmodule

/* hw/text_overlay_mux.sv */
`timescale 1ns/1ps

module text_overlay_mux
   import text_geom_pkg::*;
   import battle_text_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  field_hit_t name_hit,
   input  field_hit_t hpl_hit,
   input  field_hit_t hpn_hit,
   input  field_hit_t move_hit,
   output glyph_req_t glyph,
   output logic       text_on
);

   // drop the hit flag, keep the glyph request
   function automatic glyph_req_t req_of(input field_hit_t h);
      glyph_req_t r;
      r.chr = h.chr;
      r.col = h.col;
      r.row = h.row;
      return r;
   endfunction

   glyph_req_t glyph_next;
   logic       text_on_next;

   // fields never overlap on screen
   // fixed order still keeps the pick defined
   always_comb begin
      text_on_next = 1'b1;
      if (name_hit.hit) begin
         glyph_next = req_of(name_hit);
      end else if (hpl_hit.hit) begin
         glyph_next = req_of(hpl_hit);
      end else if (hpn_hit.hit) begin
         glyph_next = req_of(hpn_hit);
      end else if (move_hit.hit) begin
         glyph_next = req_of(move_hit);
      end else begin
         // background pixel, blank glyph at cell origin
         text_on_next = 1'b0;
         glyph_next   = '{chr: CHR_BLANK, col: '0, row: '0};
      end
   end

   // one stage toward the glyph rom
   always_ff @(posedge clk) begin
      if (rst) begin
         text_on <= 1'b0;
         glyph   <= '{chr: CHR_BLANK, col: '0, row: '0};
      end else begin
         text_on <= text_on_next;
         glyph   <= glyph_next;
      end
   end

endmodule

/* hw/battle_text_overlay.sv */
`timescale 1ns/1ps

module battle_text_overlay
   import text_geom_pkg::*;
   import battle_text_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  pixel_pos_t  pos,
   input  species_id_t species_id,
   input  move_id_t    move_id,
   input  hp_t         cur_hp,
   input  hp_t         max_hp,
   output glyph_req_t  glyph,
   output logic        text_on
);

   name_str_t  name_str;
   move_str_t  move_str;
   hpn_str_t   hpn_str;
   field_hit_t name_hit;
   field_hit_t hpl_hit;
   field_hit_t hpn_hit;
   field_hit_t move_hit;

   // string sources, all combinational
   battle_name_rom u_name_rom (
      .species_id (species_id),
      .move_id    (move_id),
      .name_str   (name_str),
      .move_str   (move_str)
   );

   hp_readout_fmt u_hp_fmt (
      .cur_hp  (cur_hp),
      .max_hp  (max_hp),
      .hpn_str (hpn_str)
   );

   // one locator per field, each at its own origin
   text_field #(.str_t(name_str_t), .x0(NAME_X0), .y0(NAME_Y0)) u_name_field (
      .pos (pos),
      .str (name_str),
      .hit (name_hit)
   );

   // label text never changes
   text_field #(.str_t(hpl_str_t), .x0(HPL_X0), .y0(HPL_Y0)) u_hpl_field (
      .pos (pos),
      .str (HP_LABEL),
      .hit (hpl_hit)
   );

   text_field #(.str_t(hpn_str_t), .x0(HPN_X0), .y0(HPN_Y0)) u_hpn_field (
      .pos (pos),
      .str (hpn_str),
      .hit (hpn_hit)
   );

   text_field #(.str_t(move_str_t), .x0(MOVE_X0), .y0(MOVE_Y0)) u_move_field (
      .pos (pos),
      .str (move_str),
      .hit (move_hit)
   );

   // merge and register, the only state in the block
   text_overlay_mux u_mux (
      .clk      (clk),
      .rst      (rst),
      .name_hit (name_hit),
      .hpl_hit  (hpl_hit),
      .hpn_hit  (hpn_hit),
      .move_hit (move_hit),
      .glyph    (glyph),
      .text_on  (text_on)
   );

endmodule

/* bench/tb_text_model.svh */
// species the bench drives, blank padded to the field width
function automatic name_str_t name_text(input species_id_t id);
   name_str_t s;
   s = 'x;
   if (id == 3'd5) begin
      s = "PIKACHU  ";
   end
   return s;
endfunction

// known moves, ids past the table give an empty box
function automatic move_str_t move_text(input move_id_t id);
   move_str_t s;
   case (id)
      5'd0:    s = "HYDRO PUMP  ";
      5'd12:   s = "THUNDERBOLT ";
      default: s = (int'(id) >= MOVE_COUNT) ? {MOVE_LEN{CHR_BLANK}} : 'x;
   endcase
   return s;
endfunction

// right aligned three digit values, leading zeros shown as blanks
function automatic hpn_str_t readout_text(input hp_t cur_val, input hp_t max_val);
   string    s;
   hpn_str_t r;
   int       i;
   s = $sformatf("%3d/%3d", int'(cur_val), int'(max_val));
   for (i = 0; i < HPN_LEN; i++) begin
      r[HPN_LEN-1-i] = s[i];
   end
   return r;
endfunction

// one text rectangle, leftmost glyph in the top byte of s
function automatic field_hit_t field_lookup(input int x, input int y, input int x0,
                                            input int y0, input int len,
                                            input logic [95:0] s);
   field_hit_t f;
   int         k;
   f = '{hit: 1'b0, chr: CHR_BLANK, col: '0, row: '0};
   if (x >= x0 && x < x0 + len * GLYPH_W && y >= y0 && y < y0 + GLYPH_H) begin
      k     = (x - x0) / GLYPH_W;
      f.hit = 1'b1;
      f.chr = s[(len-1-k)*8 +: 8];
      f.col = glyph_col_t'((x - x0) % GLYPH_W);
      f.row = glyph_row_t'(y - y0);
   end
   return f;
endfunction

// first hit wins: name, label, readout, move
function automatic field_hit_t pixel_model(input pixel_pos_t p, input species_id_t sp,
                                           input move_id_t mv, input hp_t cur_val,
                                           input hp_t max_val);
   int         x;
   int         y;
   field_hit_t f;
   x = int'(p.draw_x);
   y = int'(p.draw_y);
   f = field_lookup(x, y, int'(NAME_X0), int'(NAME_Y0), NAME_LEN, 96'(name_text(sp)));
   if (!f.hit) begin
      f = field_lookup(x, y, int'(HPL_X0), int'(HPL_Y0), HPL_LEN, 96'("HP"));
   end
   if (!f.hit) begin
      f = field_lookup(x, y, int'(HPN_X0), int'(HPN_Y0), HPN_LEN,
                       96'(readout_text(cur_val, max_val)));
   end
   if (!f.hit) begin
      f = field_lookup(x, y, int'(MOVE_X0), int'(MOVE_Y0), MOVE_LEN, 96'(move_text(mv)));
   end
   return f;
endfunction

/* bench/tb_battle_text_overlay.sv */
`timescale 1ns/1ps

module tb_battle_text_overlay
   import text_geom_pkg::*;
   import battle_text_pkg::*;
();

   `include "tb_text_model.svh"

   logic        clk;
   logic        rst;
   pixel_pos_t  pos;
   species_id_t species_id;
   move_id_t    move_id;
   hp_t         cur_hp;
   hp_t         max_hp;
   glyph_req_t  glyph;
   logic        text_on;

   // model output delayed like the DUT register
   field_hit_t  exp_q;
   logic        armed;
   int          edges_seen;
   int          seed;

   battle_text_overlay uut (
      .clk        (clk),
      .rst        (rst),
      .pos        (pos),
      .species_id (species_id),
      .move_id    (move_id),
      .cur_hp     (cur_hp),
      .max_hp     (max_hp),
      .glyph      (glyph),
      .text_on    (text_on)
   );

   // 4 ns period
   always #2 clk = ~clk;

   always @(posedge clk) begin
      // checks start once reset has been seen
      armed      <= armed | rst;
      edges_seen <= edges_seen + 1;
      if (rst) begin
         exp_q <= '{hit: 1'b0, chr: CHR_BLANK, col: '0, row: '0};
      end else begin
         exp_q <= pixel_model(pos, species_id, move_id, cur_hp, max_hp);
      end
   end

   task automatic value_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
      $display("FAILED %s got %h expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "output mismatch");
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timed out while waiting for %s", what);
      $display("Testbench failed");
      $fatal(1, "timeout");
   endtask

   // outputs against the model, one cycle after the inputs
   a_text_on: assert property (@(posedge clk) armed |-> text_on == exp_q.hit)
      else value_mismatch("text_on", 8'($sampled(text_on)), 8'($sampled(exp_q.hit)));
   a_chr: assert property (@(posedge clk) armed |-> glyph.chr == exp_q.chr)
      else value_mismatch("glyph.chr", $sampled(glyph.chr), $sampled(exp_q.chr));
   a_col: assert property (@(posedge clk) armed |-> glyph.col == exp_q.col)
      else value_mismatch("glyph.col", 8'($sampled(glyph.col)), 8'($sampled(exp_q.col)));
   a_row: assert property (@(posedge clk) armed |-> glyph.row == exp_q.row)
      else value_mismatch("glyph.row", 8'($sampled(glyph.row)), 8'($sampled(exp_q.row)));

   // lands 1 ns after the next rising edge
   task automatic next_edge();
      int start;
      int waited;
      start  = edges_seen;
      waited = 0;
      while (edges_seen == start) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > 4) begin
            abort_on_timeout("the next clock edge");
         end
      end
   endtask

   task automatic apply_pixel(input int x, input int y);
      pos.draw_x = coord_t'(x);
      pos.draw_y = coord_t'(y);
      next_edge();
   endtask

   // whole field plus a one pixel ring around it
   task automatic scan_field(input coord_t x0, input coord_t y0, input int len);
      int x;
      int y;
      for (y = int'(y0) - 1; y <= int'(y0) + GLYPH_H; y++) begin
         for (x = int'(x0) - 1; x <= int'(x0) + len * GLYPH_W; x++) begin
            apply_pixel(x, y);
         end
      end
   endtask

   task automatic readout_check(input hp_t cur_val, input hp_t max_val);
      cur_hp = cur_val;
      max_hp = max_val;
      scan_field(HPN_X0, HPN_Y0, HPN_LEN);
   endtask

   initial begin
      int k;
      int r;
      int p;
      int waited;
      int target;
      clk        = 1'b0;
      rst        = 1'b1;
      armed      = 1'b0;
      edges_seen = 0;
      seed       = 32'hd110;
      pos        = '0;
      species_id = 3'd5;
      move_id    = 5'd12;
      cur_hp     = 7'd100;
      max_hp     = 7'd100;
      // two reset cycles, then background pixels
      next_edge();
      next_edge();
      rst = 1'b0;
      apply_pixel(0, 0);
      apply_pixel(0, 0);
      scan_field(NAME_X0, NAME_Y0, NAME_LEN);
      scan_field(MOVE_X0, MOVE_Y0, MOVE_LEN);
      move_id = 5'd0;
      scan_field(MOVE_X0, MOVE_Y0, MOVE_LEN);
      // ids past the move table
      for (k = 26; k < 32; k++) begin
         move_id = move_id_t'(k);
         scan_field(MOVE_X0, MOVE_Y0, MOVE_LEN);
      end
      scan_field(HPL_X0, HPL_Y0, HPL_LEN);
      readout_check(7'd100, 7'd100);
      readout_check(7'd37, 7'd50);
      readout_check(7'd5, 7'd100);
      readout_check(7'd0, 7'd127);
      // random pixels near the text, ids the model knows
      for (k = 0; k < 200; k++) begin
         r = $random(seed);
         p = $random(seed);
         move_id = (r[2:0] == 3'd0) ? 5'd0 :
                   (r[2:0] == 3'd1) ? 5'd12 : move_id_t'(24 + int'(r[2:0]));
         cur_hp  = hp_t'(r[9:3]);
         max_hp  = hp_t'(r[16:10]);
         apply_pixel(56 + int'(p[24:17]) % 160,
                     p[25] ? 40 + int'(p[31:26]) : 392 + int'(p[30:26]));
      end
      // let the last pixel reach its check
      target = edges_seen + 1;
      waited = 0;
      while (edges_seen < target) begin
         @(negedge clk);
         waited++;
         if (waited > 4) begin
            abort_on_timeout("the last check");
         end
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+bench
hw/text_geom_pkg.sv
hw/battle_text_pkg.sv
hw/battle_name_rom.sv
hw/hp_readout_fmt.sv
hw/text_field.sv
hw/text_overlay_mux.sv
hw/battle_text_overlay.sv
bench/tb_battle_text_overlay.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_battle_text_overlay
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
